// File: build.f
rtl/mc51_sfr_pkg.sv
rtl/mc51_cycle_pkg.sv
rtl/mc51_cycle_ctrl.sv
rtl/mc51_operand_buf.sv
rtl/mc51_pc_unit.sv
rtl/mc51_core_regs.sv
rtl/mc51_iram.sv
rtl/mc51_cu.sv
test/tb_clock_gen.sv
test/mc51_cu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= mc51_cu_tb
FILELIST  ?= build.f
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: test/mc51_cu_tb.sv
// Table-driven testbench of the 8051 control unit with a random-delay memory responder
`timescale 1ns/1ps
`default_nettype none

module mc51_cu_tb;

	localparam int N_ROWS     = 16;
	localparam int WAIT_LIMIT = 200;

	// One instruction, its memory bytes and the expected results
	typedef struct packed {
		mc51_cycle_pkg::decode_t  dec;
		mc51_cycle_pkg::addr_t    addr;
		mc51_cycle_pkg::alu_t     alu;
		logic [7:0]               wdata;
		logic [7:0]               op;
		logic [7:0]               m2;
		logic [7:0]               m3;
		logic [15:0]              pc;
		mc51_sfr_pkg::core_regs_t regs;
		mc51_cycle_pkg::bufs_t    bufs;
		logic                     chk_wr;
		logic                     halt;
	} row_t;

	logic                      clk;
	logic                      reset_n;
	mc51_cycle_pkg::decode_t   i_dec;
	mc51_cycle_pkg::addr_t     i_addr;
	mc51_cycle_pkg::alu_t      i_alu;
	logic [7:0]                i_mem_wdata;
	logic [7:0]                i_mem_rdata;
	logic                      i_data_rdy;
	mc51_cycle_pkg::bus_t      o_bus;
	mc51_cycle_pkg::mc_state_e o_state;
	logic [15:0]               o_pc;
	mc51_cycle_pkg::bufs_t     o_bufs;
	mc51_sfr_pkg::core_regs_t  o_regs;
	logic                      o_err_halt;

	row_t        rows [N_ROWS];
	logic [7:0]  cur_op;
	logic [7:0]  cur_m2;
	logic [7:0]  cur_m3;
	// External writes seen by the responder
	int          wr_count;
	logic [15:0] wr_addr;
	logic [7:0]  wr_data;

	tb_clock_gen #(
		.PERIOD       (8.0),
		.RESET_CYCLES (10)
	) tb_clock_gen_inst (
		.clk     (clk),
		.reset_n (reset_n)
	);

	mc51_cu #(
		.IRAM_DEPTH (128)
	) mc51_cu_inst (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_dec       (i_dec),
		.i_addr      (i_addr),
		.i_alu       (i_alu),
		.i_mem_wdata (i_mem_wdata),
		.i_mem_rdata (i_mem_rdata),
		.i_data_rdy  (i_data_rdy),
		.o_bus       (o_bus),
		.o_state     (o_state),
		.o_pc        (o_pc),
		.o_bufs      (o_bufs),
		.o_regs      (o_regs),
		.o_err_halt  (o_err_halt)
	);

	task automatic stop_on_error();
		$display("Test failures found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_regs(input string name, input mc51_sfr_pkg::core_regs_t got,
			input mc51_sfr_pkg::core_regs_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_bufs(input string name, input mc51_cycle_pkg::bufs_t got,
			input mc51_cycle_pkg::bufs_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_pc(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_bus(input string name, input mc51_cycle_pkg::bus_t got,
			input mc51_cycle_pkg::bus_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_state(input string name, input mc51_cycle_pkg::mc_state_e got,
			input mc51_cycle_pkg::mc_state_e exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %s expected %s", $time, name,
				got.name(), exp.name());
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_write(input int count_before, input row_t row);
		if (wr_count != count_before + 1) begin
			$display("Expected one external RAM write, saw %0d", wr_count - count_before);
			stop_on_error();
		end
		check_pc("ext write address", wr_addr, row.addr.s5);
		check_pc("ext write data", {8'h00, wr_data}, {8'h00, row.wdata});
	endtask

	// Polls on falling edges until the FSM reaches the stage
	task automatic wait_for_state(input mc51_cycle_pkg::mc_state_e target);
		int cycles;
		cycles = 0;
		while (o_state !== target) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("Timed out waiting for stage %s, stuck in %s", target.name(),
					o_state.name());
				stop_on_error();
			end
		end
	endtask

	// Returns on the falling edge after a rising edge taken under reset
	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (reset_n !== 1'b0) begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("Timed out waiting for reset to be applied");
				stop_on_error();
			end
		end
		@(negedge clk);
	endtask

	function automatic mc51_cycle_pkg::decode_t mk_dec(
		input mc51_cycle_pkg::fetch_mode_e s2,
		input mc51_cycle_pkg::fetch_mode_e s3,
		input mc51_cycle_pkg::write_mode_e wr,
		input logic                        upd2,
		input logic                        upd3,
		input mc51_sfr_pkg::reg_tar_e      tar,
		input mc51_sfr_pkg::reg_sor_e      sor,
		input mc51_cycle_pkg::pc_reload_e  pcm,
		input logic                        jp
	);
		mc51_cycle_pkg::decode_t d;
		d.s2_mode   = s2;
		d.s3_mode   = s3;
		d.wr_mode   = wr;
		d.s2_upd_pc = upd2;
		d.s3_upd_pc = upd3;
		d.reg_tar   = tar;
		d.reg_sor   = sor;
		d.pc_mode   = pcm;
		d.jp_active = jp;
		return d;
	endfunction

	function automatic row_t make_row(
		input mc51_cycle_pkg::decode_t  dec,
		input logic [47:0]              addr,
		input logic [24:0]              alu,
		input logic [7:0]               wdata,
		input logic [23:0]              mem,
		input logic [15:0]              pc,
		input logic [47:0]              regs,
		input logic [23:0]              bufs,
		input logic                     chk_wr,
		input logic                     halt
	);
		row_t r;
		r.dec    = dec;
		r.addr   = addr;
		r.alu    = alu;
		r.wdata  = wdata;
		r.op     = mem[23:16];
		r.m2     = mem[15:8];
		r.m3     = mem[7:0];
		r.pc     = pc;
		r.regs   = regs;
		r.bufs   = bufs;
		r.chk_wr = chk_wr;
		r.halt   = halt;
		return r;
	endfunction

	// Regs order acc b sp dpl dph psw, addr order s2 s3 s5, alu o1 o2 psw ready
	task automatic build_table();
		// Two external ROM operands, both advancing the PC
		rows[0] = make_row(mk_dec(mc51_cycle_pkg::IND_EXROM, mc51_cycle_pkg::IND_EXROM,
			mc51_cycle_pkg::WR_DISCARD, 1'b1, 1'b1, mc51_sfr_pkg::TO_IDLE,
			mc51_sfr_pkg::FROM_NULL, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0100_0101_0000, {24'h000000, 1'b1}, 8'h00, 24'h123456, 16'h0003,
			48'h00_00_07_00_00_00, 24'h123456, 1'b0, 1'b0);
		// ROM then external RAM, S3 leaves the PC alone
		rows[1] = make_row(mk_dec(mc51_cycle_pkg::IND_EXROM, mc51_cycle_pkg::IND_EXRAM,
			mc51_cycle_pkg::WR_DISCARD, 1'b1, 1'b0, mc51_sfr_pkg::TO_B,
			mc51_sfr_pkg::FROM_S3, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0102_4000_0000, {24'h000081, 1'b1}, 8'h00, 24'h21A53C, 16'h0005,
			48'h00_3C_07_00_00_81, 24'h21A53C, 1'b0, 1'b0);
		// Direct write to internal RAM 30
		rows[2] = make_row(mk_dec(mc51_cycle_pkg::DISCARD, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_DIR_IRAM, 1'b0, 1'b0, mc51_sfr_pkg::TO_IDLE,
			mc51_sfr_pkg::FROM_NULL, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0000_0000_0030, {24'h000000, 1'b1}, 8'h5A, 24'hF50000, 16'h0006,
			48'h00_3C_07_00_00_00, 24'hF5A53C, 1'b0, 1'b0);
		// Read it back into ACC
		rows[3] = make_row(mk_dec(mc51_cycle_pkg::DIR_IRAM, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_DISCARD, 1'b0, 1'b0, mc51_sfr_pkg::TO_ACC,
			mc51_sfr_pkg::FROM_S2, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0030_0000_0000, {24'h000000, 1'b1}, 8'h00, 24'hE50000, 16'h0007,
			48'h5A_3C_07_00_00_00, 24'hE55A3C, 1'b0, 1'b0);
		// Direct write to E0 lands in ACC
		rows[4] = make_row(mk_dec(mc51_cycle_pkg::DISCARD, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_DIR_IRAM, 1'b0, 1'b0, mc51_sfr_pkg::TO_IDLE,
			mc51_sfr_pkg::FROM_NULL, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0000_0000_00E0, {24'h000000, 1'b1}, 8'h77, 24'h750000, 16'h0008,
			48'h77_3C_07_00_00_00, 24'h755A3C, 1'b0, 1'b0);
		// Unknown SFR 99 reads zero, E0 reads ACC
		rows[5] = make_row(mk_dec(mc51_cycle_pkg::DIR_IRAM, mc51_cycle_pkg::DIR_IRAM,
			mc51_cycle_pkg::WR_DISCARD, 1'b0, 1'b0, mc51_sfr_pkg::TO_B,
			mc51_sfr_pkg::FROM_S2, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0099_00E0_0000, {24'h000000, 1'b1}, 8'h00, 24'h850000, 16'h0009,
			48'h77_00_07_00_00_00, 24'h850077, 1'b0, 1'b0);
		// ALU results into DPL, DPH and SP with new flags
		rows[6] = make_row(mk_dec(mc51_cycle_pkg::DISCARD, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_DISCARD, 1'b0, 1'b0, mc51_sfr_pkg::TO_DPL,
			mc51_sfr_pkg::FROM_A_TEMP, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0, {24'h1020C4, 1'b1}, 8'h00, 24'h040000, 16'h000A,
			48'h77_00_07_10_00_C4, 24'h040077, 1'b0, 1'b0);
		rows[7] = make_row(mk_dec(mc51_cycle_pkg::DISCARD, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_DISCARD, 1'b0, 1'b0, mc51_sfr_pkg::TO_DPH,
			mc51_sfr_pkg::FROM_B_TEMP, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0, {24'h332001, 1'b1}, 8'h00, 24'h050000, 16'h000B,
			48'h77_00_07_10_20_01, 24'h050077, 1'b0, 1'b0);
		rows[8] = make_row(mk_dec(mc51_cycle_pkg::DISCARD, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_DISCARD, 1'b0, 1'b0, mc51_sfr_pkg::TO_SP,
			mc51_sfr_pkg::FROM_A_TEMP, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0, {24'h509900, 1'b1}, 8'h00, 24'h060000, 16'h000C,
			48'h77_00_50_10_20_00, 24'h060077, 1'b0, 1'b0);
		// Relative jump back by 4 from 000E
		rows[9] = make_row(mk_dec(mc51_cycle_pkg::IND_EXROM, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_DISCARD, 1'b1, 1'b0, mc51_sfr_pkg::TO_IDLE,
			mc51_sfr_pkg::FROM_NULL, mc51_cycle_pkg::PC_REL2, 1'b1),
			48'h0200_0000_0000, {24'h000000, 1'b1}, 8'h00, 24'h80FC00, 16'h000A,
			48'h77_00_50_10_20_00, 24'h80FC77, 1'b0, 1'b0);
		rows[10] = make_row(mk_dec(mc51_cycle_pkg::IND_EXROM, mc51_cycle_pkg::IND_EXROM,
			mc51_cycle_pkg::WR_DISCARD, 1'b1, 1'b1, mc51_sfr_pkg::TO_IDLE,
			mc51_sfr_pkg::FROM_NULL, mc51_cycle_pkg::PC_16B, 1'b1),
			48'h0200_0201_0000, {24'h000000, 1'b1}, 8'h00, 24'h023412, 16'h1234,
			48'h77_00_50_10_20_00, 24'h023412, 1'b0, 1'b0);
		// ACC 77 plus DPTR 2010
		rows[11] = make_row(mk_dec(mc51_cycle_pkg::DISCARD, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_DISCARD, 1'b0, 1'b0, mc51_sfr_pkg::TO_IDLE,
			mc51_sfr_pkg::FROM_NULL, mc51_cycle_pkg::PC_IND, 1'b1),
			48'h0, {24'h000000, 1'b1}, 8'h00, 24'h730000, 16'h2087,
			48'h77_00_50_10_20_00, 24'h733412, 1'b0, 1'b0);
		// 2K page jump from 2089, opcode bits 101
		rows[12] = make_row(mk_dec(mc51_cycle_pkg::IND_EXROM, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_DISCARD, 1'b1, 1'b0, mc51_sfr_pkg::TO_IDLE,
			mc51_sfr_pkg::FROM_NULL, mc51_cycle_pkg::PC_11B, 1'b1),
			48'h2088_0000_0000, {24'h000000, 1'b1}, 8'h00, 24'hA15C00, 16'h255C,
			48'h77_00_50_10_20_00, 24'hA15C12, 1'b0, 1'b0);
		// Jump kind set but not taken
		rows[13] = make_row(mk_dec(mc51_cycle_pkg::IND_EXROM, mc51_cycle_pkg::IND_EXROM,
			mc51_cycle_pkg::WR_DISCARD, 1'b1, 1'b1, mc51_sfr_pkg::TO_IDLE,
			mc51_sfr_pkg::FROM_NULL, mc51_cycle_pkg::PC_16B, 1'b0),
			48'h255D_255E_0000, {24'h000000, 1'b1}, 8'h00, 24'h02AABB, 16'h255F,
			48'h77_00_50_10_20_00, 24'h02AABB, 1'b0, 1'b0);
		rows[14] = make_row(mk_dec(mc51_cycle_pkg::DISCARD, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_EXRAM, 1'b0, 1'b0, mc51_sfr_pkg::TO_IDLE,
			mc51_sfr_pkg::FROM_NULL, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0000_0000_1234, {24'h000000, 1'b1}, 8'h9E, 24'hF00000, 16'h2560,
			48'h77_00_50_10_20_00, 24'hF0AABB, 1'b1, 1'b0);
		// Indirect @90 is upper space, FSM halts
		rows[15] = make_row(mk_dec(mc51_cycle_pkg::IND_IRAM, mc51_cycle_pkg::DISCARD,
			mc51_cycle_pkg::WR_DISCARD, 1'b0, 1'b0, mc51_sfr_pkg::TO_IDLE,
			mc51_sfr_pkg::FROM_NULL, mc51_cycle_pkg::PC_NUL, 1'b0),
			48'h0090_0000_0000, {24'h000000, 1'b1}, 8'h00, 24'hE60000, 16'h2561,
			48'h77_00_50_10_20_00, 24'hE6AABB, 1'b0, 1'b1);
	endtask

	// Memory responder, answers each wait stage after 0 to 3 cycles
	initial begin
		int delay;
		int seed_dummy;
		seed_dummy  = $urandom(32'hcace3b3f);
		delay       = 0;
		i_data_rdy  = 1'b0;
		i_mem_rdata = 8'h00;
		wr_count    = 0;
		wr_addr     = 16'h0000;
		wr_data     = 8'h00;
		forever begin
			@(negedge clk);
			i_data_rdy = 1'b0;
			case (o_state)
				mc51_cycle_pkg::S1_1, mc51_cycle_pkg::S2_1, mc51_cycle_pkg::S3_1,
				mc51_cycle_pkg::S5_1: begin
					if (delay == 0) begin
						i_data_rdy = 1'b1;
						case (o_state)
							mc51_cycle_pkg::S1_1: begin
								check_bus("o_bus fetch", o_bus, 3'b001);
								i_mem_rdata = cur_op;
							end
							mc51_cycle_pkg::S2_1: begin
								check_bus("o_bus s2 read", o_bus, {1'b0,
									i_dec.s2_mode == mc51_cycle_pkg::IND_EXRAM, 1'b1});
								i_mem_rdata = cur_m2;
							end
							mc51_cycle_pkg::S3_1: begin
								check_bus("o_bus s3 read", o_bus, {1'b0,
									i_dec.s3_mode == mc51_cycle_pkg::IND_EXRAM, 1'b1});
								i_mem_rdata = cur_m3;
							end
							default: begin
								// We_n low, psen_n high
								check_bus("o_bus ext write", o_bus, 3'b110);
								wr_addr = i_addr.s5;
								wr_data = i_mem_wdata;
								wr_count++;
							end
						endcase
					end else begin
						delay--;
					end
				end
				default: delay = $urandom % 4;
			endcase
		end
	end

	initial begin
		int   wr_before;
		row_t row;
		i_dec       = '0;
		i_addr      = '0;
		i_alu       = '0;
		i_mem_wdata = 8'h00;
		cur_op      = 8'h00;
		cur_m2      = 8'h00;
		cur_m3      = 8'h00;
		build_table();
		wait_for_reset();
		// Reset values, sampled while reset is still held
		check_state("o_state", o_state, mc51_cycle_pkg::S1_0);
		check_bus("o_bus", o_bus, 3'b111);
		check_pc("o_pc", o_pc, mc51_sfr_pkg::PC_RESET);
		check_pc("o_regs.sp", {8'h00, o_regs.sp}, {8'h00, mc51_sfr_pkg::SP_RESET});
		check_flag("o_err_halt", o_err_halt, 1'b0);
		for (int i = 0; i < N_ROWS; i++) begin
			row         = rows[i];
			wr_before   = wr_count;
			i_dec       = row.dec;
			i_addr      = row.addr;
			i_alu       = row.alu;
			i_mem_wdata = row.wdata;
			cur_op      = row.op;
			cur_m2      = row.m2;
			cur_m3      = row.m3;
			if (row.halt) begin
				wait_for_state(mc51_cycle_pkg::HALT_LOOP);
				repeat (3) @(negedge clk);
				check_state("o_state", o_state, mc51_cycle_pkg::HALT_LOOP);
				check_flag("o_err_halt", o_err_halt, 1'b1);
				check_bus("o_bus", o_bus, 3'b111);
			end else begin
				wait_for_state(mc51_cycle_pkg::S6_0);
				wait_for_state(mc51_cycle_pkg::S1_0);
				check_flag("o_err_halt", o_err_halt, 1'b0);
			end
			check_pc("o_pc", o_pc, row.pc);
			check_regs("o_regs", o_regs, row.regs);
			check_bufs("o_bufs", o_bufs, row.bufs);
			if (row.chk_wr) begin
				check_write(wr_before, row);
			end else if (wr_count != wr_before) begin
				$display("Unexpected external RAM write in row %0d", i);
				stop_on_error();
			end
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// Testbench clock and reset source, 8 ns clock with reset held low for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD       = 8.0,
	parameter int  RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/mc51_cu.sv
// Top of the 8051 control unit, cycle FSM plus buffers, PC, core regs and IRAM
`timescale 1ns/1ps
`default_nettype none

module mc51_cu #(
	parameter int IRAM_DEPTH = 128
) (
	input  wire                        clk,
	input  wire                        reset_n,
	input  mc51_cycle_pkg::decode_t    i_dec,
	input  mc51_cycle_pkg::addr_t      i_addr,
	input  mc51_cycle_pkg::alu_t       i_alu,
	input  wire  [7:0]                 i_mem_wdata,
	input  wire  [7:0]                 i_mem_rdata,
	input  wire                        i_data_rdy,
	output mc51_cycle_pkg::bus_t       o_bus,
	output mc51_cycle_pkg::mc_state_e  o_state,
	output logic [15:0]                o_pc,
	output mc51_cycle_pkg::bufs_t      o_bufs,
	output mc51_sfr_pkg::core_regs_t   o_regs,
	output logic                       o_err_halt
);

	mc51_cycle_pkg::buf_ctrl_t buf_ctrl;
	logic       pc_inc;
	logic       pc_reload;
	logic       alu_load;
	logic       sfr_wr;
	logic       iram_we;
	logic [7:0] iram_rd2;
	logic [7:0] iram_rd3;
	logic [7:0] sfr_rd2;
	logic [7:0] sfr_rd3;

	mc51_cycle_ctrl mc51_cycle_ctrl_inst (
		.clk          (clk),
		.reset_n      (reset_n),
		.i_dec        (i_dec),
		.i_addr_hi_s2 (i_addr.s2[7]),
		.i_addr_hi_s3 (i_addr.s3[7]),
		.i_addr_hi_s5 (i_addr.s5[7]),
		.i_data_rdy   (i_data_rdy),
		.i_alu_ready  (i_alu.ready),
		.o_state      (o_state),
		.o_bus        (o_bus),
		.o_buf        (buf_ctrl),
		.o_pc_inc     (pc_inc),
		.o_pc_reload  (pc_reload),
		.o_alu_load   (alu_load),
		.o_sfr_wr     (sfr_wr),
		.o_iram_we    (iram_we),
		.o_err_halt   (o_err_halt)
	);

	mc51_operand_buf mc51_operand_buf_inst (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_ctrl      (buf_ctrl),
		.i_mem_rdata (i_mem_rdata),
		.i_iram_rd2  (iram_rd2),
		.i_iram_rd3  (iram_rd3),
		.i_sfr_rd2   (sfr_rd2),
		.i_sfr_rd3   (sfr_rd3),
		.o_bufs      (o_bufs)
	);

	mc51_pc_unit mc51_pc_unit_inst (
		.clk      (clk),
		.reset_n  (reset_n),
		.i_inc    (pc_inc),
		.i_reload (pc_reload),
		.i_mode   (i_dec.pc_mode),
		.i_bufs   (o_bufs),
		.i_regs   (o_regs),
		.o_pc     (o_pc)
	);

	mc51_core_regs mc51_core_regs_inst (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_alu_load  (alu_load),
		.i_sfr_wr    (sfr_wr),
		.i_tar       (i_dec.reg_tar),
		.i_sor       (i_dec.reg_sor),
		.i_alu       (i_alu),
		.i_bufs      (o_bufs),
		.i_addr      (i_addr),
		.i_mem_wdata (i_mem_wdata),
		.o_regs      (o_regs),
		.o_sfr_rd2   (sfr_rd2),
		.o_sfr_rd3   (sfr_rd3)
	);

	mc51_iram #(
		.IRAM_DEPTH (IRAM_DEPTH)
	) mc51_iram_inst (
		.clk     (clk),
		.i_we    (iram_we),
		.i_addr  (i_addr),
		.i_wdata (i_mem_wdata),
		.o_rd2   (iram_rd2),
		.o_rd3   (iram_rd3)
	);

endmodule

`default_nettype wire

// File: rtl/mc51_iram.sv
// Lower internal RAM, one write port at s5 and read ports at s2 and s3
`timescale 1ns/1ps
`default_nettype none

module mc51_iram #(
	parameter int IRAM_DEPTH = 128
) (
	input  wire                    clk,
	input  wire                    i_we,
	input  mc51_cycle_pkg::addr_t  i_addr,
	input  wire  [7:0]             i_wdata,
	output logic [7:0]             o_rd2,
	output logic [7:0]             o_rd3
);

	localparam int AW = $clog2(IRAM_DEPTH);

	logic [7:0] mem [IRAM_DEPTH];

	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_addr.s5[AW-1:0]] <= i_wdata;
		end
	end

	// Reads are asynchronous
	assign o_rd2 = mem[i_addr.s2[AW-1:0]];
	assign o_rd3 = mem[i_addr.s3[AW-1:0]];

endmodule

`default_nettype wire

// File: rtl/mc51_core_regs.sv
// Core SFRs ACC, B, SP, DPTR and PSW with direct read and write decode
`timescale 1ns/1ps
`default_nettype none

module mc51_core_regs (
	input  wire                        clk,
	input  wire                        reset_n,
	input  wire                        i_alu_load,
	input  wire                        i_sfr_wr,
	input  mc51_sfr_pkg::reg_tar_e     i_tar,
	input  mc51_sfr_pkg::reg_sor_e     i_sor,
	input  mc51_cycle_pkg::alu_t       i_alu,
	input  mc51_cycle_pkg::bufs_t      i_bufs,
	input  mc51_cycle_pkg::addr_t      i_addr,
	input  wire  [7:0]                 i_mem_wdata,
	output mc51_sfr_pkg::core_regs_t   o_regs,
	output logic [7:0]                 o_sfr_rd2,
	output logic [7:0]                 o_sfr_rd3
);

	logic [7:0] reg_wdata;

	// Unknown SFRs read as zero
	function automatic logic [7:0] sfr_read(
		input logic [7:0]               addr,
		input mc51_sfr_pkg::core_regs_t regs
	);
		case (addr)
			mc51_sfr_pkg::SFR_ACC: sfr_read = regs.acc;
			mc51_sfr_pkg::SFR_B:   sfr_read = regs.b;
			mc51_sfr_pkg::SFR_SP:  sfr_read = regs.sp;
			mc51_sfr_pkg::SFR_DPL: sfr_read = regs.dpl;
			mc51_sfr_pkg::SFR_DPH: sfr_read = regs.dph;
			mc51_sfr_pkg::SFR_PSW: sfr_read = regs.psw;
			default:               sfr_read = 8'h00;
		endcase
	endfunction

	assign o_sfr_rd2 = sfr_read(i_addr.s2[7:0], o_regs);
	assign o_sfr_rd3 = sfr_read(i_addr.s3[7:0], o_regs);

	// S4 load data
	always_comb begin
		case (i_sor)
			mc51_sfr_pkg::FROM_S2:     reg_wdata = i_bufs.s2;
			mc51_sfr_pkg::FROM_S3:     reg_wdata = i_bufs.s3;
			mc51_sfr_pkg::FROM_A_TEMP: reg_wdata = i_alu.o1;
			mc51_sfr_pkg::FROM_B_TEMP: reg_wdata = i_alu.o2;
			default:                   reg_wdata = 8'h00;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			o_regs.acc <= 8'h00;
			o_regs.b   <= 8'h00;
			o_regs.sp  <= mc51_sfr_pkg::SP_RESET;
			o_regs.dpl <= 8'h00;
			o_regs.dph <= 8'h00;
			o_regs.psw <= mc51_sfr_pkg::PSW_RESET;
		end else if (i_alu_load) begin
			// Flags always follow the ALU
			o_regs.psw <= i_alu.psw;
			case (i_tar)
				mc51_sfr_pkg::TO_ACC: o_regs.acc <= reg_wdata;
				mc51_sfr_pkg::TO_B:   o_regs.b   <= reg_wdata;
				mc51_sfr_pkg::TO_SP:  o_regs.sp  <= reg_wdata;
				mc51_sfr_pkg::TO_DPH: o_regs.dph <= reg_wdata;
				mc51_sfr_pkg::TO_DPL: o_regs.dpl <= reg_wdata;
				default: ;
			endcase
		end else if (i_sfr_wr) begin
			// S5 direct write, other addresses dropped
			case (i_addr.s5[7:0])
				mc51_sfr_pkg::SFR_ACC: o_regs.acc <= i_mem_wdata;
				mc51_sfr_pkg::SFR_B:   o_regs.b   <= i_mem_wdata;
				mc51_sfr_pkg::SFR_SP:  o_regs.sp  <= i_mem_wdata;
				mc51_sfr_pkg::SFR_DPL: o_regs.dpl <= i_mem_wdata;
				mc51_sfr_pkg::SFR_DPH: o_regs.dph <= i_mem_wdata;
				mc51_sfr_pkg::SFR_PSW: o_regs.psw <= i_mem_wdata;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/mc51_pc_unit.sv
// Program counter of the 8051 control unit with increment and jump reload
`timescale 1ns/1ps
`default_nettype none

module mc51_pc_unit (
	input  wire                         clk,
	input  wire                         reset_n,
	input  wire                         i_inc,
	input  wire                         i_reload,
	input  mc51_cycle_pkg::pc_reload_e  i_mode,
	input  mc51_cycle_pkg::bufs_t       i_bufs,
	input  mc51_sfr_pkg::core_regs_t    i_regs,
	output logic [15:0]                 o_pc
);

	logic [15:0] pc_d;

	always_comb begin
		pc_d = o_pc;
		if (i_inc) begin
			pc_d = o_pc + 16'd1;
		end else if (i_reload) begin
			case (i_mode)
				// AJMP style, stays in the 2K page
				mc51_cycle_pkg::PC_11B: pc_d = {o_pc[15:11], i_bufs.instr[7:5], i_bufs.s2};
				mc51_cycle_pkg::PC_REL2: pc_d = o_pc + {{8{i_bufs.s2[7]}}, i_bufs.s2};
				mc51_cycle_pkg::PC_REL3: pc_d = o_pc + {{8{i_bufs.s3[7]}}, i_bufs.s3};
				// JMP @A+DPTR
				mc51_cycle_pkg::PC_IND: pc_d = {8'h00, i_regs.acc} + {i_regs.dph, i_regs.dpl};
				mc51_cycle_pkg::PC_16B: pc_d = {i_bufs.s3, i_bufs.s2};
				default: pc_d = o_pc;
			endcase
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			o_pc <= mc51_sfr_pkg::PC_RESET;
		end else begin
			o_pc <= pc_d;
		end
	end

endmodule

`default_nettype wire

// File: rtl/mc51_operand_buf.sv
// Instruction and S2/S3 operand buffers of the 8051 control unit
`timescale 1ns/1ps
`default_nettype none

module mc51_operand_buf (
	input  wire                        clk,
	input  wire                        reset_n,
	input  mc51_cycle_pkg::buf_ctrl_t  i_ctrl,
	input  wire  [7:0]                 i_mem_rdata,
	input  wire  [7:0]                 i_iram_rd2,
	input  wire  [7:0]                 i_iram_rd3,
	input  wire  [7:0]                 i_sfr_rd2,
	input  wire  [7:0]                 i_sfr_rd3,
	output mc51_cycle_pkg::bufs_t      o_bufs
);

	logic [7:0] s2_src;
	logic [7:0] s3_src;

	// Source mux, memory unless internal space
	always_comb begin
		case (i_ctrl.src)
			mc51_cycle_pkg::SRC_IRAM: begin
				s2_src = i_iram_rd2;
				s3_src = i_iram_rd3;
			end
			mc51_cycle_pkg::SRC_SFR: begin
				s2_src = i_sfr_rd2;
				s3_src = i_sfr_rd3;
			end
			default: begin
				s2_src = i_mem_rdata;
				s3_src = i_mem_rdata;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			o_bufs <= '0;
		end else begin
			// Opcode always comes from program memory
			if (i_ctrl.ld_instr) begin
				o_bufs.instr <= i_mem_rdata;
			end
			if (i_ctrl.ld_s2) begin
				o_bufs.s2 <= s2_src;
			end
			if (i_ctrl.ld_s3) begin
				o_bufs.s3 <= s3_src;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/mc51_cycle_ctrl.sv
// Machine cycle FSM of the 8051 control unit, drives bus and datapath strobes
`timescale 1ns/1ps
`default_nettype none

module mc51_cycle_ctrl (
	input  wire                        clk,
	input  wire                        reset_n,
	input  mc51_cycle_pkg::decode_t    i_dec,
	input  wire                        i_addr_hi_s2,
	input  wire                        i_addr_hi_s3,
	input  wire                        i_addr_hi_s5,
	input  wire                        i_data_rdy,
	input  wire                        i_alu_ready,
	output mc51_cycle_pkg::mc_state_e  o_state,
	output mc51_cycle_pkg::bus_t       o_bus,
	output mc51_cycle_pkg::buf_ctrl_t  o_buf,
	output logic                       o_pc_inc,
	output logic                       o_pc_reload,
	output logic                       o_alu_load,
	output logic                       o_sfr_wr,
	output logic                       o_iram_we,
	output logic                       o_err_halt
);

	mc51_cycle_pkg::mc_state_e state_q;
	mc51_cycle_pkg::mc_state_e state_d;
	// Stage that follows a finished S2 fetch
	mc51_cycle_pkg::mc_state_e s2_next;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state_q <= mc51_cycle_pkg::S1_0;
		end else begin
			state_q <= state_d;
		end
	end

	assign s2_next = (i_dec.s3_mode == mc51_cycle_pkg::DISCARD) ?
		mc51_cycle_pkg::S4_0 : mc51_cycle_pkg::S3_0;

	always_comb begin
		state_d     = state_q;
		o_bus       = '1;
		o_buf       = '0;
		o_buf.src   = mc51_cycle_pkg::SRC_MEM;
		o_pc_inc    = 1'b0;
		o_pc_reload = 1'b0;
		o_alu_load  = 1'b0;
		o_sfr_wr    = 1'b0;
		o_iram_we   = 1'b0;
		case (state_q)
			// Opcode fetch from program memory
			mc51_cycle_pkg::S1_0: begin
				o_bus.rd_n   = 1'b0;
				o_bus.psen_n = 1'b0;
				state_d      = mc51_cycle_pkg::S1_1;
			end
			mc51_cycle_pkg::S1_1: begin
				o_bus.rd_n   = 1'b0;
				o_bus.psen_n = 1'b0;
				if (i_data_rdy) begin
					o_buf.ld_instr = 1'b1;
					o_pc_inc       = 1'b1;
					state_d        = mc51_cycle_pkg::S2_0;
				end
			end
			mc51_cycle_pkg::S2_0: begin
				case (i_dec.s2_mode)
					mc51_cycle_pkg::DISCARD: state_d = mc51_cycle_pkg::S4_0;
					mc51_cycle_pkg::IND_EXROM, mc51_cycle_pkg::IND_EXRAM: begin
						o_bus.rd_n   = 1'b0;
						o_bus.psen_n = (i_dec.s2_mode == mc51_cycle_pkg::IND_EXRAM);
						state_d      = mc51_cycle_pkg::S2_1;
					end
					mc51_cycle_pkg::IND_IRAM, mc51_cycle_pkg::DIR_IRAM: begin
						// Indirect access cannot reach the upper space
						if (i_addr_hi_s2 && i_dec.s2_mode == mc51_cycle_pkg::IND_IRAM) begin
							state_d = mc51_cycle_pkg::HALT_LOOP;
						end else begin
							o_buf.ld_s2 = 1'b1;
							o_buf.src   = i_addr_hi_s2 ? mc51_cycle_pkg::SRC_SFR :
								mc51_cycle_pkg::SRC_IRAM;
							state_d     = s2_next;
						end
					end
					default: state_d = mc51_cycle_pkg::HALT_LOOP;
				endcase
			end
			mc51_cycle_pkg::S2_1: begin
				o_bus.rd_n   = 1'b0;
				o_bus.psen_n = (i_dec.s2_mode == mc51_cycle_pkg::IND_EXRAM);
				if (i_data_rdy) begin
					o_buf.ld_s2 = 1'b1;
					o_pc_inc    = i_dec.s2_upd_pc;
					state_d     = s2_next;
				end
			end
			mc51_cycle_pkg::S3_0: begin
				case (i_dec.s3_mode)
					mc51_cycle_pkg::DISCARD: state_d = mc51_cycle_pkg::S4_0;
					mc51_cycle_pkg::IND_EXROM, mc51_cycle_pkg::IND_EXRAM: begin
						o_bus.rd_n   = 1'b0;
						o_bus.psen_n = (i_dec.s3_mode == mc51_cycle_pkg::IND_EXRAM);
						state_d      = mc51_cycle_pkg::S3_1;
					end
					mc51_cycle_pkg::IND_IRAM, mc51_cycle_pkg::DIR_IRAM: begin
						if (i_addr_hi_s3 && i_dec.s3_mode == mc51_cycle_pkg::IND_IRAM) begin
							state_d = mc51_cycle_pkg::HALT_LOOP;
						end else begin
							o_buf.ld_s3 = 1'b1;
							o_buf.src   = i_addr_hi_s3 ? mc51_cycle_pkg::SRC_SFR :
								mc51_cycle_pkg::SRC_IRAM;
							state_d     = mc51_cycle_pkg::S4_0;
						end
					end
					default: state_d = mc51_cycle_pkg::HALT_LOOP;
				endcase
			end
			mc51_cycle_pkg::S3_1: begin
				o_bus.rd_n   = 1'b0;
				o_bus.psen_n = (i_dec.s3_mode == mc51_cycle_pkg::IND_EXRAM);
				if (i_data_rdy) begin
					o_buf.ld_s3 = 1'b1;
					o_pc_inc    = i_dec.s3_upd_pc;
					state_d     = mc51_cycle_pkg::S4_0;
				end
			end
			// Hold until the ALU result is valid
			mc51_cycle_pkg::S4_0: begin
				if (i_alu_ready) begin
					state_d = mc51_cycle_pkg::S4_1;
				end
			end
			mc51_cycle_pkg::S4_1: begin
				o_alu_load = 1'b1;
				state_d    = mc51_cycle_pkg::S5_0;
			end
			// Write-back
			mc51_cycle_pkg::S5_0: begin
				case (i_dec.wr_mode)
					mc51_cycle_pkg::WR_DISCARD: state_d = mc51_cycle_pkg::S6_0;
					mc51_cycle_pkg::WR_IND_IRAM, mc51_cycle_pkg::WR_DIR_IRAM: begin
						if (!i_addr_hi_s5) begin
							o_iram_we = 1'b1;
							state_d   = mc51_cycle_pkg::S6_0;
						end else if (i_dec.wr_mode == mc51_cycle_pkg::WR_DIR_IRAM) begin
							o_sfr_wr = 1'b1;
							state_d  = mc51_cycle_pkg::S6_0;
						end else begin
							state_d = mc51_cycle_pkg::HALT_LOOP;
						end
					end
					mc51_cycle_pkg::WR_EXRAM: begin
						o_bus.we_n = 1'b0;
						state_d    = mc51_cycle_pkg::S5_1;
					end
					default: state_d = mc51_cycle_pkg::HALT_LOOP;
				endcase
			end
			mc51_cycle_pkg::S5_1: begin
				o_bus.we_n = 1'b0;
				if (i_data_rdy) begin
					state_d = mc51_cycle_pkg::S6_0;
				end
			end
			// Jump reload, then next instruction
			mc51_cycle_pkg::S6_0: begin
				o_pc_reload = i_dec.jp_active;
				state_d     = mc51_cycle_pkg::S1_0;
			end
			default: state_d = mc51_cycle_pkg::HALT_LOOP;
		endcase
		// Bus stays idle while reset is held
		if (!reset_n) begin
			o_bus = '1;
		end
	end

	assign o_state    = state_q;
	assign o_err_halt = (state_q == mc51_cycle_pkg::HALT_LOOP);

endmodule

`default_nettype wire

// File: rtl/mc51_cycle_pkg.sv
// Machine cycle states, addressing modes and control structs of the 8051 control unit
`default_nettype none

package mc51_cycle_pkg;

	// S1 to S6 stage encoding
	typedef enum logic [3:0] {
		S1_0,
		S1_1,
		S2_0,
		S2_1,
		S3_0,
		S3_1,
		S4_0,
		S4_1,
		S5_0,
		S5_1,
		S6_0,
		HALT_LOOP
	} mc_state_e;

	// Operand source for S2 and S3
	typedef enum logic [2:0] {
		DISCARD,
		IND_EXROM,
		IND_EXRAM,
		IND_IRAM,
		DIR_IRAM
	} fetch_mode_e;

	// S5 write-back target
	typedef enum logic [2:0] {
		WR_DISCARD,
		WR_IND_IRAM,
		WR_DIR_IRAM,
		WR_EXRAM
	} write_mode_e;

	// Jump kinds applied in S6
	typedef enum logic [2:0] {
		PC_NUL,
		PC_11B,
		PC_REL2,
		PC_REL3,
		PC_IND,
		PC_16B
	} pc_reload_e;

	typedef enum logic [1:0] {
		SRC_MEM,
		SRC_IRAM,
		SRC_SFR
	} buf_src_e;

	// Instruction properties from the decoder
	typedef struct packed {
		fetch_mode_e              s2_mode;
		fetch_mode_e              s3_mode;
		write_mode_e              wr_mode;
		logic                     s2_upd_pc;
		logic                     s3_upd_pc;
		mc51_sfr_pkg::reg_tar_e   reg_tar;
		mc51_sfr_pkg::reg_sor_e   reg_sor;
		pc_reload_e               pc_mode;
		logic                     jp_active;
	} decode_t;

	typedef struct packed {
		logic [15:0] s2;
		logic [15:0] s3;
		logic [15:0] s5;
	} addr_t;

	typedef struct packed {
		logic [7:0] o1;
		logic [7:0] o2;
		logic [7:0] psw;
		logic       ready;
	} alu_t;

	// Memory strobes, all active low
	typedef struct packed {
		logic rd_n;
		logic psen_n;
		logic we_n;
	} bus_t;

	typedef struct packed {
		logic     ld_instr;
		logic     ld_s2;
		logic     ld_s3;
		buf_src_e src;
	} buf_ctrl_t;

	typedef struct packed {
		logic [7:0] instr;
		logic [7:0] s2;
		logic [7:0] s3;
	} bufs_t;

endpackage

`default_nettype wire

// File: rtl/mc51_sfr_pkg.sv
// Core SFR map, reset values and register select types of the 8051 control unit
`default_nettype none

package mc51_sfr_pkg;

	// Core SFR addresses in the direct space
	localparam logic [7:0] SFR_ACC = 8'hE0;
	localparam logic [7:0] SFR_B   = 8'hF0;
	localparam logic [7:0] SFR_SP  = 8'h81;
	localparam logic [7:0] SFR_DPL = 8'h82;
	localparam logic [7:0] SFR_DPH = 8'h83;
	localparam logic [7:0] SFR_PSW = 8'hD0;

	// Start of the upper space, SFRs when direct
	localparam logic [7:0] IRAM_UPPER_BASE = 8'h80;

	localparam logic [15:0] PC_RESET  = 16'h0000;
	localparam logic [7:0]  SP_RESET  = 8'h07;
	localparam logic [7:0]  PSW_RESET = 8'h00;

	// Register loaded in S4
	typedef enum logic [2:0] {
		TO_ACC,
		TO_B,
		TO_SP,
		TO_DPH,
		TO_DPL,
		TO_IDLE
	} reg_tar_e;

	// Data that goes into it
	typedef enum logic [2:0] {
		FROM_NULL,
		FROM_S2,
		FROM_S3,
		FROM_A_TEMP,
		FROM_B_TEMP
	} reg_sor_e;

	typedef struct packed {
		logic [7:0] acc;
		logic [7:0] b;
		logic [7:0] sp;
		logic [7:0] dpl;
		logic [7:0] dph;
		logic [7:0] psw;
	} core_regs_t;

endpackage

`default_nettype wire
